//--- verilog/memPkg.sv
package memPkg;

    // Cache geometry
    localparam int wordWidth  = 32;
    localparam int blockWords = 16;
    localparam int blockWidth = 512;
    localparam int numLines   = 16;
    localparam int indexBits  = 4;
    localparam int offsetBits = 4;

    // Byte offset inside a word, and where the line index starts
    localparam int byteBits = 2;
    localparam int blockLsb = byteBits + offsetBits;
    localparam int tagBits  = wordWidth - indexBits - blockLsb;

    typedef logic [wordWidth-1:0]  word_t;
    typedef logic [blockWidth-1:0] block_t;
    typedef logic [indexBits-1:0]  lineIndex_t;
    typedef logic [tagBits-1:0]    tag_t;
    typedef logic [offsetBits-1:0] wordSel_t;

    // Access FSM of the memory stage
    typedef enum logic [3:0] {
        IDLE     = 4'd0,
        READ     = 4'd1,
        EVICT_RD = 4'd2,
        LOAD_RD  = 4'd3,
        WAIT_RD  = 4'd4,
        WRITE    = 4'd5,
        EVICT_WR = 4'd6,
        LOAD_WR  = 4'd7,
        WAIT_WR  = 4'd8
    } stageState_t;

    // Block request from stage to controller
    typedef struct packed {
        logic   evict;
        logic   fill;
        word_t  blkAddr;
        block_t blkData;
    } memReq_t;

    // Block response from controller to stage
    typedef struct packed {
        logic   evictDone;
        logic   fillValid;
        block_t fillData;
    } memRsp_t;

    // Wishbone classic master outputs
    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        word_t adr;
        word_t dat;
    } wbReq_t;

    // Wishbone classic slave outputs
    typedef struct packed {
        logic  ack;
        word_t dat;
    } wbRsp_t;

    // Data region is odd parity over the top nibble
    function automatic logic inDataRegion(word_t a);
        return ^a[31:28];
    endfunction

    // FFT buffers sit where bits 29..28 have odd parity
    function automatic logic inFftRegion(word_t a);
        return ^a[29:28];
    endfunction

endpackage

//--- verilog/dataCache.sv
`timescale 1ns/1ns

module dataCache (
    input  logic           clk,
    input  logic           rst,
    input  logic           en,
    input  logic           rd,
    input  logic           wr,
    input  logic           ld,
    input  memPkg::word_t  addr,
    input  memPkg::word_t  dataIn,
    input  memPkg::block_t blkIn,
    output memPkg::word_t  dataOut,
    output logic           hit,
    output logic           evictNeeded,
    output memPkg::word_t  victimAddr,
    output memPkg::block_t blkOut
);
    import memPkg::*;

    // Per-line state bits
    logic [numLines-1:0] validArr;
    logic [numLines-1:0] dirtyArr;

    // Tag and block storage
    tag_t   tagArr   [numLines];
    block_t blockArr [numLines];

    // Address split
    lineIndex_t index;
    tag_t       tag;
    wordSel_t   wordSel;

    // Lookup results
    logic lineValid;
    logic lineDirty;
    logic tagMatch;
    tag_t storedTag;

    // Qualified updates
    logic doLoad;
    logic doWrite;

    // Byte address: tag | index | word | byte
    assign index   = addr[blockLsb +: indexBits];
    assign tag     = addr[wordWidth-1 -: tagBits];
    assign wordSel = addr[byteBits +: offsetBits];

    assign lineValid = validArr[index];
    assign lineDirty = dirtyArr[index];
    assign storedTag = tagArr[index];
    assign tagMatch  = (storedTag == tag);

    // Lookup is purely combinational
    assign hit = en && lineValid && tagMatch;

    // Only a dirty valid line has to go back to memory before the fill
    assign evictNeeded = en && !hit && lineValid && lineDirty;

    // Victim sits at the same index with its own tag
    assign victimAddr = {storedTag, index, {blockLsb{1'b0}}};

    // Whole block for write-back
    assign blkOut = blockArr[index];

    // Word select out of the indexed block
    always_comb begin
        dataOut = '0;
        if (en && rd) begin
            dataOut = blockArr[index][wordSel*wordWidth +: wordWidth];
        end
    end

    // Load wins over a store in the same cycle
    assign doLoad  = en && ld;
    assign doWrite = en && wr && hit && !ld;

    // Valid and dirty bits
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            validArr <= '0;
            dirtyArr <= '0;
        end else begin
            if (doLoad) begin
                // Fresh block from memory is clean
                validArr[index] <= 1'b1;
                dirtyArr[index] <= 1'b0;
            end else if (doWrite) begin
                dirtyArr[index] <= 1'b1;
            end
        end
    end

    // Tag array
    always_ff @(posedge clk) begin
        if (doLoad) begin
            tagArr[index] <= tag;
        end
    end

    // Block array, whole-block fill or single word store
    always_ff @(posedge clk) begin
        if (doLoad) begin
            blockArr[index] <= blkIn;
        end else if (doWrite) begin
            blockArr[index][wordSel*wordWidth +: wordWidth] <= dataIn;
        end
    end

endmodule

//--- verilog/memoryStage.sv
`timescale 1ns/1ns

module memoryStage (
    input  logic            clk,
    input  logic            rst,
    input  logic            memRead,
    input  logic            memWrite,
    input  memPkg::word_t   addr,
    input  memPkg::word_t   writeData,
    input  logic            fftCalculating,
    output memPkg::word_t   memoryOut,
    output logic            stall,
    output logic            memAccessEx,
    output logic            memWriteEx,
    output logic            fftNotCompleteEx,
    // Cache side
    output logic            cacheEn,
    output logic            cacheRd,
    output logic            cacheWr,
    output logic            cacheLd,
    output memPkg::word_t   cacheAddr,
    output memPkg::word_t   cacheDataIn,
    output memPkg::block_t  cacheBlkIn,
    input  memPkg::word_t   cacheDataOut,
    input  logic            cacheHit,
    input  logic            cacheEvictNeeded,
    input  memPkg::word_t   cacheVictimAddr,
    input  memPkg::block_t  cacheBlkOut,
    // Controller side
    output memPkg::memReq_t mcReq,
    input  memPkg::memRsp_t mcRsp
);
    import memPkg::*;

    stageState_t currState;
    stageState_t nextState;

    logic  anyEx;
    logic  dataRegion;
    logic  fftRegion;
    word_t blockBase;

    // Region checks on the current request
    assign dataRegion = inDataRegion(addr);
    assign fftRegion  = inFftRegion(addr);

    // Exceptions follow the request inputs directly
    assign memWriteEx       = memWrite && !fftCalculating && !dataRegion;
    assign memAccessEx      = memRead && !fftCalculating && !dataRegion;
    assign fftNotCompleteEx = (memRead || memWrite) && fftCalculating && fftRegion;
    assign anyEx            = memWriteEx || memAccessEx || fftNotCompleteEx;

    // Block aligned address of the request, used for the fill
    assign blockBase = {addr[wordWidth-1:blockLsb], {blockLsb{1'b0}}};

    // The pipeline holds addr and data until stall drops
    assign cacheAddr   = addr;
    assign cacheDataIn = writeData;
    assign cacheBlkIn  = mcRsp.fillData;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            currState <= IDLE;
        end else begin
            currState <= nextState;
        end
    end

    always_comb begin
        nextState     = currState;
        memoryOut     = '0;
        stall         = 1'b0;
        cacheEn       = 1'b0;
        cacheRd       = 1'b0;
        cacheWr       = 1'b0;
        cacheLd       = 1'b0;
        mcReq.evict   = 1'b0;
        mcReq.fill    = 1'b0;
        mcReq.blkAddr = blockBase;
        mcReq.blkData = cacheBlkOut;

        case (currState)
            IDLE: begin
                // Faulting requests never leave IDLE
                stall = (memRead || memWrite) && !anyEx;
                if (memRead && !anyEx) begin
                    nextState = READ;
                end else if (memWrite && !anyEx) begin
                    nextState = WRITE;
                end
            end
            READ: begin
                cacheEn   = 1'b1;
                cacheRd   = 1'b1;
                memoryOut = cacheDataOut;
                stall     = !cacheHit;
                if (cacheHit) begin
                    nextState = IDLE;
                end else if (cacheEvictNeeded) begin
                    nextState = EVICT_RD;
                end else begin
                    nextState = LOAD_RD;
                end
            end
            WRITE: begin
                cacheEn = 1'b1;
                cacheWr = 1'b1;
                stall   = !cacheHit;
                if (cacheHit) begin
                    nextState = IDLE;
                end else if (cacheEvictNeeded) begin
                    nextState = EVICT_WR;
                end else begin
                    nextState = LOAD_WR;
                end
            end
            EVICT_RD, EVICT_WR: begin
                // Victim block goes out to its own address
                cacheEn       = 1'b1;
                stall         = 1'b1;
                mcReq.evict   = 1'b1;
                mcReq.blkAddr = cacheVictimAddr;
                if (mcRsp.evictDone) begin
                    nextState = (currState == EVICT_RD) ? LOAD_RD : LOAD_WR;
                end
            end
            LOAD_RD, LOAD_WR: begin
                // Install the block on the fillValid pulse
                cacheEn    = 1'b1;
                stall      = 1'b1;
                mcReq.fill = 1'b1;
                cacheLd    = mcRsp.fillValid;
                if (mcRsp.fillValid) begin
                    nextState = (currState == LOAD_RD) ? WAIT_RD : WAIT_WR;
                end
            end
            WAIT_RD: begin
                stall     = 1'b1;
                nextState = READ;
            end
            WAIT_WR: begin
                stall     = 1'b1;
                nextState = WRITE;
            end
            default: begin
                stall     = 1'b1;
                nextState = IDLE;
            end
        endcase
    end

endmodule

//--- verilog/memController.sv
`timescale 1ns/1ns

module memController (
    input  logic            clk,
    input  logic            rst,
    input  memPkg::memReq_t req,
    output memPkg::memRsp_t rsp,
    output memPkg::wbReq_t  wbOut,
    input  memPkg::wbRsp_t  wbIn
);
    import memPkg::*;

    typedef enum logic [1:0] {
        MC_IDLE,
        MC_WB,
        MC_FILL,
        MC_DONE
    } ctrlState_t;

    ctrlState_t state;
    logic       strobe;
    logic       wasEvict;
    wordSel_t   wordCnt;
    block_t     fillShift;
    logic       ackSeen;
    logic       lastWord;

    // One word transfer finishes on an ack while strobed
    assign ackSeen  = strobe && wbIn.ack;
    assign lastWord = (wordCnt == wordSel_t'(blockWords - 1));

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state    <= MC_IDLE;
            strobe   <= 1'b0;
            wasEvict <= 1'b0;
            wordCnt  <= '0;
        end else begin
            case (state)
                MC_IDLE: begin
                    wordCnt <= '0;
                    // Write-back first when both are asked for
                    if (req.evict) begin
                        state    <= MC_WB;
                        wasEvict <= 1'b1;
                    end else if (req.fill) begin
                        state    <= MC_FILL;
                        wasEvict <= 1'b0;
                    end
                end
                MC_WB, MC_FILL: begin
                    if (!strobe) begin
                        strobe <= 1'b1;
                    end else if (ackSeen) begin
                        // Bus goes idle one cycle between words
                        strobe <= 1'b0;
                        if (lastWord) begin
                            state <= MC_DONE;
                        end else begin
                            wordCnt <= wordCnt + 1'b1;
                        end
                    end
                end
                MC_DONE: state <= MC_IDLE;
                default: state <= MC_IDLE;
            endcase
        end
    end

    // Words shift in from the top, word 0 ends up lowest
    always_ff @(posedge clk) begin
        if (state == MC_FILL && ackSeen) begin
            fillShift <= {wbIn.dat, fillShift[blockWidth-1:wordWidth]};
        end
    end

    always_comb begin
        wbOut.cyc     = strobe;
        wbOut.stb     = strobe;
        wbOut.we      = (state == MC_WB);
        wbOut.adr     = req.blkAddr + word_t'({wordCnt, {byteBits{1'b0}}});
        wbOut.dat     = req.blkData[wordCnt*wordWidth +: wordWidth];
        // Single-cycle completion pulses
        rsp.evictDone = (state == MC_DONE) && wasEvict;
        rsp.fillValid = (state == MC_DONE) && !wasEvict;
        rsp.fillData  = fillShift;
    end

endmodule

//--- verilog/memSubsystem.sv
`timescale 1ns/1ns

module memSubsystem (
    input  logic           clk,
    input  logic           rst,
    input  logic           memRead,
    input  logic           memWrite,
    input  memPkg::word_t  addr,
    input  memPkg::word_t  writeData,
    input  logic           fftCalculating,
    output memPkg::word_t  memoryOut,
    output logic           stall,
    output logic           memAccessEx,
    output logic           memWriteEx,
    output logic           fftNotCompleteEx,
    output memPkg::wbReq_t wbOut,
    input  memPkg::wbRsp_t wbIn
);
    import memPkg::*;

    // Stage to cache
    logic   cacheEn;
    logic   cacheRd;
    logic   cacheWr;
    logic   cacheLd;
    word_t  cacheAddr;
    word_t  cacheDataIn;
    block_t cacheBlkIn;

    // Cache to stage
    word_t  cacheDataOut;
    logic   cacheHit;
    logic   cacheEvictNeeded;
    word_t  cacheVictimAddr;
    block_t cacheBlkOut;

    // Stage and controller handshake
    memReq_t mcReq;
    memRsp_t mcRsp;

    memoryStage stage_i (
        .clk(clk),
        .rst(rst),
        .memRead(memRead),
        .memWrite(memWrite),
        .addr(addr),
        .writeData(writeData),
        .fftCalculating(fftCalculating),
        .memoryOut(memoryOut),
        .stall(stall),
        .memAccessEx(memAccessEx),
        .memWriteEx(memWriteEx),
        .fftNotCompleteEx(fftNotCompleteEx),
        .cacheEn(cacheEn),
        .cacheRd(cacheRd),
        .cacheWr(cacheWr),
        .cacheLd(cacheLd),
        .cacheAddr(cacheAddr),
        .cacheDataIn(cacheDataIn),
        .cacheBlkIn(cacheBlkIn),
        .cacheDataOut(cacheDataOut),
        .cacheHit(cacheHit),
        .cacheEvictNeeded(cacheEvictNeeded),
        .cacheVictimAddr(cacheVictimAddr),
        .cacheBlkOut(cacheBlkOut),
        .mcReq(mcReq),
        .mcRsp(mcRsp)
    );

    dataCache cache_i (
        .clk(clk),
        .rst(rst),
        .en(cacheEn),
        .rd(cacheRd),
        .wr(cacheWr),
        .ld(cacheLd),
        .addr(cacheAddr),
        .dataIn(cacheDataIn),
        .blkIn(cacheBlkIn),
        .dataOut(cacheDataOut),
        .hit(cacheHit),
        .evictNeeded(cacheEvictNeeded),
        .victimAddr(cacheVictimAddr),
        .blkOut(cacheBlkOut)
    );

    memController ctrl_i (
        .clk(clk),
        .rst(rst),
        .req(mcReq),
        .rsp(mcRsp),
        .wbOut(wbOut),
        .wbIn(wbIn)
    );

endmodule

//--- dv/memSubsystem_properties.sv
`timescale 1ns/1ns

module memSubsystem_properties (
    input logic           clk,
    input logic           rst,
    input logic           memRead,
    input logic           memWrite,
    input memPkg::word_t  memoryOut,
    input logic           stall,
    input logic           memAccessEx,
    input logic           memWriteEx,
    input logic           fftNotCompleteEx,
    input logic           cacheHit,
    input memPkg::wbReq_t wbOut,
    input memPkg::wbRsp_t wbIn
);
    // Failed assertions so far, watched from the testbench
    int errCount = 0;

    logic anyEx;
    logic anyReq;

    assign anyEx  = memAccessEx || memWriteEx || fftNotCompleteEx;
    assign anyReq = memRead || memWrite;

    // Bus and stall quiet while reset is held
    rstQuiet: assert property (@(posedge clk) rst |-> !wbOut.cyc && !wbOut.stb && !stall)
        else begin
            errCount++;
            $error("Bus or stall active during reset");
        end

    // Cycle and strobe both drop for one cycle after each ack
    ackGap: assert property (@(posedge clk) disable iff (rst)
        wbOut.stb && wbIn.ack |=> !wbOut.cyc && !wbOut.stb)
        else begin
            errCount++;
            $error("Wishbone cycle not dropped after ack");
        end

    // Transfer held steady until the slave acks
    busHeld: assert property (@(posedge clk) disable iff (rst)
        wbOut.stb && !wbIn.ack |=> wbOut.stb && $stable(wbOut.adr) && $stable(wbOut.we)
                                   && $stable(wbOut.dat))
        else begin
            errCount++;
            $error("Wishbone transfer changed before ack");
        end

    // At most one exception per request
    oneEx: assert property (@(posedge clk) disable iff (rst)
        $onehot0({memAccessEx, memWriteEx, fftNotCompleteEx}))
        else begin
            errCount++;
            $error("More than one exception raised");
        end

    // A faulting request never stalls the pipeline
    exNoStall: assert property (@(posedge clk) disable iff (rst) anyEx |-> !stall)
        else begin
            errCount++;
            $error("Stall raised for a faulting request");
        end

    // Stall low on a live request only when the line hits
    stallOnHit: assert property (@(posedge clk) disable iff (rst)
        anyReq && !anyEx && !stall |-> cacheHit)
        else begin
            errCount++;
            $error("Stall dropped without a cache hit");
        end

    // Completed load carries known data
    readKnown: assert property (@(posedge clk) disable iff (rst)
        memRead && !anyEx && !stall |-> !$isunknown(memoryOut))
        else begin
            errCount++;
            $error("Load completed with unknown data");
        end

endmodule

bind memSubsystem memSubsystem_properties props_i (
    .clk(clk),
    .rst(rst),
    .memRead(memRead),
    .memWrite(memWrite),
    .memoryOut(memoryOut),
    .stall(stall),
    .memAccessEx(memAccessEx),
    .memWriteEx(memWriteEx),
    .fftNotCompleteEx(fftNotCompleteEx),
    .cacheHit(cacheHit),
    .wbOut(wbOut),
    .wbIn(wbIn)
);

//--- dv/memSubsystemTb.sv
`timescale 1ns/1ns

module memSubsystemTb;
    import memPkg::*;

    // Longest stall a write-back plus fill may take, in cycles
    localparam int stallTimeout = 2000;

    logic   clk;
    logic   rst;
    logic   memRead;
    logic   memWrite;
    word_t  addr;
    word_t  writeData;
    logic   fftCalculating;
    word_t  memoryOut;
    logic   stall;
    logic   memAccessEx;
    logic   memWriteEx;
    logic   fftNotCompleteEx;
    wbReq_t wbOut;
    wbRsp_t wbIn = '0;

    // Wait states of the slave come from here
    integer seed = 36;

    // Slave memory and expected contents, keyed by byte address of the word
    word_t slaveMem [word_t];
    word_t shadow [word_t];

    // Slave handshake state
    int waitLeft;
    bit armed;

    // Results of the last access
    int cycles;
    bit sawBus;

    memSubsystem memSubsystem_i (
        .clk(clk),
        .rst(rst),
        .memRead(memRead),
        .memWrite(memWrite),
        .addr(addr),
        .writeData(writeData),
        .fftCalculating(fftCalculating),
        .memoryOut(memoryOut),
        .stall(stall),
        .memAccessEx(memAccessEx),
        .memWriteEx(memWriteEx),
        .fftNotCompleteEx(fftNotCompleteEx),
        .wbOut(wbOut),
        .wbIn(wbIn)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Untouched memory holds its address with a marker in the upper half
    function automatic word_t initPattern(word_t a);
        return a ^ 32'h5A5A0000;
    endfunction

    // What memory should hold now, following the completed stores
    function automatic word_t modelWord(word_t a);
        word_t w;
        w = {a[31:2], 2'b00};
        if (shadow.exists(w)) begin
            return shadow[w];
        end else begin
            return initPattern(w);
        end
    endfunction

    function automatic word_t slaveRead(word_t a);
        if (slaveMem.exists(a)) begin
            return slaveMem[a];
        end else begin
            return initPattern(a);
        end
    endfunction

    task automatic stopWithError(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic compareWord(input string name, input word_t expected, input word_t actual);
        assert (actual === expected) else begin
            stopWithError($sformatf("[FAIL] %s: expected %h, actual %h",
                                    name, expected, actual));
        end
    endtask

    // Wishbone slave, answers on the falling edge after 0 to 3 wait cycles
    always @(negedge clk) begin
        if (rst) begin
            wbIn.ack = 1'b0;
            armed    = 1'b0;
        end else if (wbIn.ack) begin
            // Ack lasts one cycle, the master drops stb on it
            wbIn.ack = 1'b0;
            armed    = 1'b0;
        end else if (wbOut.cyc && wbOut.stb) begin
            if (!armed) begin
                armed    = 1'b1;
                waitLeft = $unsigned($random(seed)) % 4;
            end
            if (waitLeft == 0) begin
                if (wbOut.we) begin
                    // Written-back words must match the expected memory
                    compareWord("write-back word", modelWord(wbOut.adr), wbOut.dat);
                    slaveMem[wbOut.adr] = wbOut.dat;
                end else begin
                    wbIn.dat = slaveRead(wbOut.adr);
                end
                wbIn.ack = 1'b1;
            end else begin
                waitLeft--;
            end
        end
    end

    // Bound assertions only count their failures
    always @(negedge clk) begin
        if (memSubsystem_i.props_i.errCount != 0) begin
            stopWithError("A bound Wishbone, stall or exception assertion failed");
        end
    end

    // One load or store, held until stall drops
    task automatic runAccess(input string name, input bit isWrite, input word_t a,
                             input word_t d, output int waited, output bit busSeen);
        waited  = 0;
        busSeen = 1'b0;
        @(negedge clk);
        memRead   = !isWrite;
        memWrite  = isWrite;
        addr      = a;
        writeData = d;
        do begin
            @(negedge clk);
            waited++;
            if (wbOut.cyc) begin
                busSeen = 1'b1;
            end
        end while (stall && waited < stallTimeout);
        if (stall) begin
            stopWithError($sformatf("%s: stall still high after %0d cycles", name, waited));
        end else begin
            // The coming rising edge completes the access
            if (isWrite) begin
                shadow[{a[31:2], 2'b00}] = d;
            end else begin
                compareWord(name, modelWord(a), memoryOut);
            end
            @(negedge clk);
            memRead  = 1'b0;
            memWrite = 1'b0;
        end
    endtask

    // Request that must fault, held a few cycles without starting
    task automatic tryFaultingAccess(input string name, input bit isWrite, input word_t a,
                                     input bit fft, input logic [2:0] expEx);
        @(negedge clk);
        memRead        = !isWrite;
        memWrite       = isWrite;
        addr           = a;
        fftCalculating = fft;
        repeat (3) begin
            @(negedge clk);
            compareWord({name, " exceptions"}, word_t'(expEx),
                        word_t'({memAccessEx, memWriteEx, fftNotCompleteEx}));
            assert (!stall && !wbOut.cyc) else begin
                stopWithError({name, ": request stalled or started a Wishbone cycle"});
            end
        end
        memRead        = 1'b0;
        memWrite       = 1'b0;
        fftCalculating = 1'b0;
    endtask

    initial begin
        rst            = 1'b1;
        memRead        = 1'b0;
        memWrite       = 1'b0;
        addr           = '0;
        writeData      = '0;
        fftCalculating = 1'b0;
        repeat (8) @(negedge clk);
        rst = 1'b0;

        // Clean miss at index 4 fetches the block
        runAccess("read miss", 1'b0, 32'h1000_0104, '0, cycles, sawBus);
        assert (sawBus) else begin
            stopWithError("Read miss finished without any Wishbone cycle");
        end

        // Same block hits, stall already low in the READ cycle
        runAccess("read hit", 1'b0, 32'h1000_0108, '0, cycles, sawBus);
        compareWord("read hit cycles", 32'd1, word_t'(cycles));
        assert (!sawBus) else begin
            stopWithError("Read hit started a Wishbone cycle");
        end

        // Store on a hit, then load it back
        runAccess("store hit", 1'b1, 32'h1000_0104, 32'hC0DE_1234, cycles, sawBus);
        runAccess("load after store", 1'b0, 32'h1000_0104, '0, cycles, sawBus);

        // Other tag at index 4 pushes out the dirty line
        runAccess("conflict read", 1'b0, 32'h1000_0504, '0, cycles, sawBus);
        runAccess("re-read after evict", 1'b0, 32'h1000_0104, '0, cycles, sawBus);

        // Store miss fills first, then retries the write
        runAccess("store miss", 1'b1, 32'h1000_0238, 32'h0BAD_F00D, cycles, sawBus);
        runAccess("load after store miss", 1'b0, 32'h1000_0238, '0, cycles, sawBus);

        // Busy FFT leaves the rest of the data region usable
        fftCalculating = 1'b1;
        runAccess("read during FFT", 1'b0, 32'h7000_0040, '0, cycles, sawBus);
        fftCalculating = 1'b0;

        // Expected flags are {memAccessEx, memWriteEx, fftNotCompleteEx}
        tryFaultingAccess("read outside data region", 1'b0, 32'h0000_0040, 1'b0, 3'b100);
        tryFaultingAccess("write outside data region", 1'b1, 32'h3000_0080, 1'b0, 3'b010);
        tryFaultingAccess("read FFT region while busy", 1'b0, 32'h1000_00C0, 1'b1, 3'b001);
        tryFaultingAccess("write FFT region while busy", 1'b1, 32'h2000_0000, 1'b1, 3'b001);
        // Outside the data region too, but a busy FFT masks the access fault
        tryFaultingAccess("read FFT region off data while busy", 1'b0, 32'h9000_0000, 1'b1,
                          3'b001);

        @(negedge clk);
        if (memSubsystem_i.props_i.errCount != 0) begin
            stopWithError("A bound assertion failed before the end of the run");
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

//--- compile.f
verilog/memPkg.sv
verilog/dataCache.sv
verilog/memoryStage.sv
verilog/memController.sv
verilog/memSubsystem.sv
dv/memSubsystem_properties.sv
dv/memSubsystemTb.sv

//--- run.sh
#!/bin/sh
# Builds the memory subsystem testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --assert --top-module memSubsystemTb -Mdir obj_dir -f compile.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

# A raised error limit keeps the run going after an assertion error,
# so the testbench can see it and stop on its own
./obj_dir/VmemSubsystemTb +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q '^\*\* PASS \*\*$' sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
